// ==== src.f ====
src/corr_pkg.sv
src/code_source.sv
src/correlator.sv
src/result_arbiter.sv
src/uart_tx.sv
src/corr_dispatch_top.sv
verification/clk_gen.sv
verification/uart_monitor.sv
verification/tb_corr_dispatch.sv

// ==== src/code_source.sv ====
`default_nettype none

module code_source #(
    parameter int HIGH_LEN    = 64,
    parameter int LOW_LEN     = 64,
    parameter int PHASE       = 0,
    parameter int START_LEVEL = 0
) (
    input  wire  clk,
    input  wire  rst,
    output logic code
);

    localparam int PERIOD     = HIGH_LEN + LOW_LEN;
    localparam int POS        = PHASE % PERIOD;  // position within one period
    localparam int FIRST_LEN  = (START_LEVEL != 0) ? HIGH_LEN : LOW_LEN;
    localparam bit IN_FIRST   = POS < FIRST_LEN;
    localparam bit INIT_LEVEL = IN_FIRST ? (START_LEVEL != 0) : (START_LEVEL == 0);
    localparam int INIT_CNT   = IN_FIRST ? POS + 1 : POS - FIRST_LEN + 1;
    localparam int MAX_LEN    = (HIGH_LEN > LOW_LEN) ? HIGH_LEN : LOW_LEN;
    localparam int RUN_W      = $clog2(MAX_LEN + 1);

    logic [RUN_W-1:0] run_cnt;  // clocks spent in current level
    logic             level;
    logic [RUN_W-1:0] cur_len;

    assign cur_len = level ? RUN_W'(HIGH_LEN) : RUN_W'(LOW_LEN);

    // reset puts the waveform PHASE clocks ahead
    always_ff @(posedge clk) begin
        if (rst) begin
            run_cnt <= RUN_W'(INIT_CNT);
            level   <= INIT_LEVEL;
        end else if (run_cnt == cur_len) begin
            run_cnt <= RUN_W'(1);
            level   <= ~level;
        end else begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    assign code = level;

endmodule

`default_nettype wire

// ==== src/corr_dispatch_top.sv ====
`default_nettype none

module corr_dispatch_top import corr_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  sig,
    output logic tx
);

    logic [NUM_CH-1:0]              code;
    logic [NUM_CH-1:0]              rdy;
    logic [NUM_CH-1:0][SCORE_W-1:0] score;
    logic [7:0]                     tx_data;
    logic                           tx_start;
    logic                           tx_busy;

    // one code source and correlator per channel
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        code_source #(
            .HIGH_LEN    (CODE_HIGH[i]),
            .LOW_LEN     (CODE_LOW[i]),
            .PHASE       (CODE_PHASE[i]),
            .START_LEVEL (CODE_START[i])
        ) code_source_i (
            .clk  (clk),
            .rst  (rst),
            .code (code[i])
        );

        correlator correlator_i (
            .clk   (clk),
            .rst   (rst),
            .sig   (sig),
            .code  (code[i]),
            .score (score[i]),
            .rdy   (rdy[i])
        );
    end

    result_arbiter result_arbiter_i (
        .clk   (clk),
        .rst   (rst),
        .rdy   (rdy),
        .score (score),
        .busy  (tx_busy),
        .data  (tx_data),
        .start (tx_start)
    );

    uart_tx uart_tx_i (
        .clk   (clk),
        .rst   (rst),
        .data  (tx_data),
        .start (tx_start),
        .tx    (tx),
        .busy  (tx_busy)
    );

endmodule

`default_nettype wire

// ==== src/corr_pkg.sv ====
`default_nettype none

package corr_pkg;

    localparam int NUM_CH     = 4;
    localparam int WINDOW_LEN = 1023;  // samples per window
    localparam int CNT_W      = 10;
    localparam int SCORE_W    = 8;     // match count without its two low bits
    localparam int CH_W       = 2;

    // chip code shape per channel
    localparam int CODE_HIGH  [NUM_CH] = '{64, 64, 64, 64};
    localparam int CODE_LOW   [NUM_CH] = '{64, 64, 64, 64};
    localparam int CODE_PHASE [NUM_CH] = '{0, 32, 64, 96};
    localparam int CODE_START [NUM_CH] = '{0, 0, 1, 1};

    localparam int BIT_CLKS   = 8;     // clocks per uart bit

endpackage

`default_nettype wire

// ==== src/correlator.sv ====
`default_nettype none

module correlator import corr_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire                sig,
    input  wire                code,
    output logic [SCORE_W-1:0] score,
    output logic               rdy
);

    logic [CNT_W-1:0] smp_cnt;
    logic [CNT_W-1:0] match_cnt;
    logic [CNT_W-1:0] match_next;  // count including this sample
    logic             last_smp;

    assign last_smp   = smp_cnt == CNT_W'(WINDOW_LEN - 1);
    assign match_next = match_cnt + CNT_W'(sig == code);

    always_ff @(posedge clk) begin
        if (rst) begin
            smp_cnt   <= '0;
            match_cnt <= '0;
            rdy       <= 1'b0;
        end else begin
            rdy <= last_smp;
            if (last_smp) begin
                smp_cnt   <= '0;  // next window starts with rdy
                match_cnt <= '0;
            end else begin
                smp_cnt   <= smp_cnt + 1'b1;
                match_cnt <= match_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (last_smp) begin
            score <= match_next[CNT_W-1 -: SCORE_W];  // drop two low bits
        end
    end

endmodule

`default_nettype wire

// ==== src/result_arbiter.sv ====
`default_nettype none

module result_arbiter import corr_pkg::*; (
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [NUM_CH-1:0]               rdy,
    input  wire  [NUM_CH-1:0][SCORE_W-1:0]  score,
    input  wire                             busy,
    output logic [7:0]                      data,
    output logic                            start
);

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_IDX      = 3'd1;  // index byte start
    localparam logic [2:0] ST_IDX_WAIT = 3'd2;
    localparam logic [2:0] ST_SCR      = 3'd3;  // score byte start
    localparam logic [2:0] ST_SCR_WAIT = 3'd4;

    logic [2:0]         state;
    logic [NUM_CH-1:0]  pending;
    logic [SCORE_W-1:0] score_buf [NUM_CH];
    logic [CH_W-1:0]    grant;      // last granted channel
    logic [CH_W-1:0]    next_ch;
    logic               found;

    // round robin search starting after grant
    always_comb begin
        logic [CH_W-1:0] cand;
        found   = 1'b0;
        next_ch = grant;
        for (int k = 1; k <= NUM_CH; k++) begin
            cand = CH_W'((int'(grant) + k) % NUM_CH);
            if (!found && pending[cand]) begin
                found   = 1'b1;
                next_ch = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CH; i++) begin
            if (rdy[i]) begin
                score_buf[i] <= score[i];  // newer score overwrites
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            pending <= '0;
            grant   <= CH_W'(NUM_CH - 1);  // channel 0 goes first
        end else begin
            case (state)
                ST_IDLE: begin
                    if (found && !busy) begin
                        state <= ST_IDX;
                        grant <= next_ch;
                    end
                end
                ST_IDX:      state <= ST_IDX_WAIT;
                ST_IDX_WAIT: begin
                    if (!busy) begin
                        state <= ST_SCR;
                    end
                end
                ST_SCR:      state <= ST_SCR_WAIT;
                ST_SCR_WAIT: begin
                    if (!busy) begin
                        state <= ST_IDLE;
                    end
                end
                default:     state <= ST_IDLE;
            endcase
            for (int i = 0; i < NUM_CH; i++) begin
                if (rdy[i]) begin
                    pending[i] <= 1'b1;
                end else if (state == ST_IDX && grant == CH_W'(i)) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    assign start = (state == ST_IDX) || (state == ST_SCR);
    assign data  = (state == ST_SCR) ? score_buf[grant] : {{(8 - CH_W){1'b0}}, grant};

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`default_nettype none

module uart_tx import corr_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire [7:0] data,
    input  wire       start,
    output logic      tx,
    output logic      busy
);

    logic [9:0]                  shreg;    // stop, data, start
    logic [$clog2(BIT_CLKS)-1:0] bit_tmr;
    logic [3:0]                  bit_cnt;
    logic                        bit_end;

    assign bit_end = bit_tmr == $bits(bit_tmr)'(BIT_CLKS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            shreg   <= '1;
            busy    <= 1'b0;
            bit_tmr <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                shreg <= {1'b1, data, 1'b0};
                busy  <= 1'b1;
            end
            bit_tmr <= '0;
            bit_cnt <= '0;
        end else if (bit_end) begin
            bit_tmr <= '0;
            shreg   <= {1'b1, shreg[9:1]};  // lsb first, refill with idle
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;  // stop bit done
            end
        end else begin
            bit_tmr <= bit_tmr + 1'b1;
        end
    end

    assign tx = shreg[0];

endmodule

`default_nettype wire

// ==== verification/clk_gen.sv ====
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released on a falling edge
    end

endmodule

`default_nettype wire

// ==== verification/tb_corr_dispatch.sv ====
`default_nettype none

module tb_corr_dispatch import corr_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES   = 3;
    localparam int MAX_WIN      = 6;
    localparam int BYTE_TIMEOUT = 2 * WINDOW_LEN;
    localparam int SEED         = 32'h6d4137f8;

    logic clk;
    logic rst;
    logic sig;
    logic tx;
    int   framing_errs;
    int   rx_q [$];
    int   smp_k;                  // samples since reset release
    int   match_cnt [NUM_CH];
    int   exp_score [MAX_WIN][NUM_CH];
    int   last_score [NUM_CH];
    int   test_errs;
    int   passed;
    int   failed;

    clk_gen clk_gen_i (.clk(clk), .rst(rst));

    corr_dispatch_top corr_dispatch_top_i (
        .clk (clk),
        .rst (rst),
        .sig (sig),
        .tx  (tx)
    );

    uart_monitor uart_monitor_i (.clk(clk), .tx(tx), .err_cnt(framing_errs));

    // square wave that had already run PHASE clocks at reset release
    function automatic logic code_model(input int ch, input int k);
        int pos;
        int first_len;
        pos       = (CODE_PHASE[ch] + k) % (CODE_HIGH[ch] + CODE_LOW[ch]);
        first_len = (CODE_START[ch] != 0) ? CODE_HIGH[ch] : CODE_LOW[ch];
        if (pos < first_len)
            return CODE_START[ch] != 0;
        return CODE_START[ch] == 0;
    endfunction

    // window 0 constant, window 1 copies channel 2, then random
    initial begin
        sig = 1'b1;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            case (smp_k / WINDOW_LEN)
                0:       sig = 1'b1;
                1:       sig = code_model(2, smp_k);
                default: sig = 1'($urandom % 2);
            endcase
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                if (sig == code_model(c, smp_k))
                    match_cnt[c]++;
            end
            if (smp_k % WINDOW_LEN == WINDOW_LEN - 1) begin
                for (int c = 0; c < NUM_CH; c++) begin
                    if (smp_k / WINDOW_LEN < MAX_WIN)
                        exp_score[smp_k / WINDOW_LEN][c] = match_cnt[c] / 4;
                    match_cnt[c] = 0;
                end
            end
            smp_k++;
        end
    end

    always begin
        @(uart_monitor_i.byte_ev);
        rx_q.push_back(uart_monitor_i.rx_byte);
    end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("[FAIL] t=%0d ns %s expected %0d got %0d", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic wait_byte(output int val, output bit ok);
        int n;
        n = 0;
        while (rx_q.size() == 0 && n < BYTE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        ok  = rx_q.size() != 0;
        val = 0;
        if (ok) begin
            val = rx_q.pop_front();
        end else begin
            $display("timeout at %0d ns: no uart byte within %0d clocks", $time, n);
            test_errs++;
        end
    endtask

    task automatic check_window(input int w, input bit in_order);
        int idx;
        int scr;
        int seen;
        bit ok;
        seen = 0;
        for (int f = 0; f < NUM_CH; f++) begin
            wait_byte(idx, ok);
            if (ok)
                wait_byte(scr, ok);
            if (ok && in_order)
                check_value("index byte", idx, f);
            if (ok && idx < NUM_CH) begin
                check_value($sformatf("score ch%0d", idx), scr, exp_score[w][idx]);
                seen          |= 1 << idx;
                last_score[idx] = scr;
            end else if (ok) begin
                check_value("index byte range", idx, NUM_CH - 1);
            end
        end
        check_value("channel mask", seen, (1 << NUM_CH) - 1);  // one frame per channel
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            passed++;
            $display("test %-16s ok", name);
        end else begin
            failed++;
            $display("test %-16s %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        passed    = 0;
        failed    = 0;
        test_errs = 0;

        for (int n = 0; n < RST_CYCLES + WINDOW_LEN && test_errs == 0; n++) begin
            @(negedge clk);
            assert (tx === 1'b1) else begin
                $display("[FAIL] t=%0d ns tx expected 1 got %b", $time, tx);
                test_errs++;
            end
        end
        finish_test("reset idle");

        check_window(0, 1'b1);
        finish_test("constant input");

        check_window(1, 1'b1);
        check_value("score ch2 matched", last_score[2], 255);  // 1023 matches
        finish_test("matched code");

        check_window(2, 1'b0);
        check_window(3, 1'b0);
        finish_test("random input");

        check_value("framing errors", framing_errs, 0);
        finish_test("serial framing");

        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/uart_monitor.sv ====
`default_nettype none

module uart_monitor import corr_pkg::*; (
    input  wire clk,
    input  wire tx,
    output int  err_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDLE_LIMIT = 2 * WINDOW_LEN;

    logic [7:0] rx_byte;
    int         byte_cnt;  // even count means an index byte is next
    event       byte_ev;

    // one bit spans BIT_CLKS falling edges, the current one first
    task automatic read_bit(input string what, output logic val);
        logic steady;
        val    = tx;
        steady = 1'b1;
        for (int n = 1; n < BIT_CLKS; n++) begin
            @(negedge clk);
            if (tx !== val)
                steady = 1'b0;
        end
        assert (steady) else begin
            $display("framing error at %0d ns: tx changed inside the %s", $time, what);
            err_cnt++;
        end
    endtask

    initial begin
        int   idle;
        int   limit;
        logic val;
        err_cnt  = 0;
        byte_cnt = 0;
        rx_byte  = '0;
        forever begin
            idle  = 0;
            limit = (byte_cnt % 2 == 1) ? BIT_CLKS : IDLE_LIMIT;  // score byte follows at once
            @(negedge clk);
            while (tx !== 1'b0 && idle < limit) begin
                idle++;
                @(negedge clk);
            end
            if (tx !== 1'b0) begin
                $display("framing error at %0d ns: no start bit within %0d clocks", $time, limit);
                err_cnt++;
                byte_cnt = 0;
            end else begin
                read_bit("start bit", val);
                for (int i = 0; i < 8; i++) begin
                    @(negedge clk);
                    read_bit("data bit", val);
                    rx_byte[i] = val;  // lsb first
                end
                @(negedge clk);
                read_bit("stop bit", val);
                assert (val === 1'b1) else begin
                    $display("[FAIL] t=%0d ns tx stop bit expected 1 got %b", $time, val);
                    err_cnt++;
                end
                byte_cnt++;
                -> byte_ev;
            end
        end
    end

endmodule

`default_nettype wire
